// File: source/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// One memory block, 16 bytes
`define BLOCK_BITS 128

// Byte address, and the block address without its 4 offset bits
`define ADDR_BITS 32
`define BLOCK_ADDR_BITS 28

// Rows of main memory, picked by the low block-address bits
`define MEM_INDEX_BITS 8
`define MEM_DEPTH 256

// Cycles from read acceptance to response
`define MEM_LATENCY 3

`endif

// File: source/mem_data_pkg.sv
`default_nettype none

`include "mem_consts.svh"

package mem_data_pkg;

    // Full byte address, used by write-through stores
    typedef logic [`ADDR_BITS-1:0] addr_t;

    // Block address, byte address without the offset bits
    typedef logic [`BLOCK_ADDR_BITS-1:0] main_mem_block_addr_t;

    typedef logic [`BLOCK_BITS-1:0] block_data_t; // One block of data

endpackage

`default_nettype wire

// File: source/mem_req_pkg.sv
`default_nettype none

package mem_req_pkg;

    // Tag that routes a read response back to its cache
    typedef enum logic {
        ICACHE = 1'b0,
        DCACHE = 1'b1
    } cache_type_t;

    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } req_type_t;

    // Store width of a write-through, in bytes 1, 2 and 4
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } req_width_t;

endpackage

`default_nettype wire

// File: source/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    // Request, taken in every cycle that req_valid is high
    logic                               req_valid;
    mem_req_pkg::cache_type_t           req_cache_type;
    mem_req_pkg::req_type_t             req_type;
    mem_data_pkg::main_mem_block_addr_t req_block_addr;
    mem_data_pkg::block_data_t          req_block_data; // Write data
    mem_req_pkg::req_width_t            req_width;      // Store width
    mem_data_pkg::addr_t                req_addr;       // Store byte address
    logic                               req_writethrough;

    // Read response, single-cycle pulse
    logic                               resp_valid;
    mem_req_pkg::cache_type_t           resp_cache_type;
    mem_data_pkg::block_data_t          resp_block_data;

    modport ctrl (
        output req_valid, req_cache_type, req_type, req_block_addr,
        output req_block_data, req_width, req_addr, req_writethrough,
        input  resp_valid, resp_cache_type, resp_block_data
    );

    modport mem (
        input  req_valid, req_cache_type, req_type, req_block_addr,
        input  req_block_data, req_width, req_addr, req_writethrough,
        output resp_valid, resp_cache_type, resp_block_data
    );

endinterface

`default_nettype wire

// File: source/mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
    // Instruction cache request, always a read
    input  wire logic                               icache_req_valid,
    input  wire mem_data_pkg::main_mem_block_addr_t icache_req_block_addr,
    output logic                                    icache_req_ready,

    // Data cache request
    input  wire logic                               dcache_req_valid,
    input  wire mem_req_pkg::req_type_t             dcache_req_type,
    input  wire mem_data_pkg::main_mem_block_addr_t dcache_req_block_addr,
    input  wire mem_data_pkg::block_data_t          dcache_req_block_data,
    input  wire mem_req_pkg::req_width_t            dcache_req_width,
    input  wire mem_data_pkg::addr_t                dcache_req_addr,
    input  wire logic                               dcache_req_writethrough,
    output logic                                    dcache_req_ready,

    mem_bus_if.ctrl                                 mem,

    // Responses back to the caches
    output logic                                    icache_resp_valid,
    output mem_data_pkg::block_data_t               icache_resp_block_data,
    output logic                                    dcache_resp_valid,
    output mem_data_pkg::block_data_t               dcache_resp_block_data
);

    // Fixed priority, the data cache waits while the instruction cache asks
    assign icache_req_ready = icache_req_valid;
    assign dcache_req_ready = dcache_req_valid && !icache_req_valid;

    always_comb begin
        mem.req_valid        = icache_req_valid || dcache_req_valid;
        mem.req_cache_type   = mem_req_pkg::ICACHE;
        mem.req_type         = mem_req_pkg::READ;
        mem.req_block_addr   = '0;
        mem.req_block_data   = '0;
        mem.req_width        = mem_req_pkg::WORD;
        mem.req_addr         = '0;
        mem.req_writethrough = 1'b0;
        if (icache_req_valid) begin
            mem.req_block_addr = icache_req_block_addr; // Fetch is a plain block read
        end else if (dcache_req_valid) begin
            mem.req_cache_type   = mem_req_pkg::DCACHE;
            mem.req_type         = dcache_req_type;
            mem.req_block_addr   = dcache_req_block_addr;
            mem.req_block_data   = dcache_req_block_data;
            mem.req_width        = dcache_req_width;
            mem.req_addr         = dcache_req_addr;
            mem.req_writethrough = dcache_req_writethrough;
        end
    end

    // Steer each response by its tag, idle port sees zero data
    always_comb begin
        icache_resp_valid      = 1'b0;
        icache_resp_block_data = '0;
        dcache_resp_valid      = 1'b0;
        dcache_resp_block_data = '0;
        if (mem.resp_valid) begin
            if (mem.resp_cache_type == mem_req_pkg::ICACHE) begin
                icache_resp_valid      = 1'b1;
                icache_resp_block_data = mem.resp_block_data;
            end else begin
                dcache_resp_valid      = 1'b1;
                dcache_resp_block_data = mem.resp_block_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/main_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module main_mem (
    input  wire logic clk,
    input  wire logic rst,
    mem_bus_if.mem    bus
);

    localparam int BLOCK_BYTES = `BLOCK_BITS / 8;
    localparam int OFFSET_BITS = $clog2(BLOCK_BYTES);

    mem_data_pkg::block_data_t mem_array [`MEM_DEPTH] = '{default: '0};

    logic [`MEM_INDEX_BITS-1:0] row_index;
    logic [OFFSET_BITS-1:0]     byte_offset;
    logic [BLOCK_BYTES-1:0]     width_mask;
    logic [BLOCK_BYTES-1:0]     byte_en;
    mem_data_pkg::block_data_t  write_block;
    logic                       wr_en;
    logic                       rd_en;

    // Array output register, then the delay line
    logic                       rd_valid;
    mem_req_pkg::cache_type_t   rd_tag;
    mem_data_pkg::block_data_t  rd_data;

    logic [`MEM_LATENCY-1:0]    pipe_valid;
    mem_req_pkg::cache_type_t   pipe_tag [`MEM_LATENCY];
    mem_data_pkg::block_data_t  pipe_data [`MEM_LATENCY];

    assign row_index   = bus.req_block_addr[`MEM_INDEX_BITS-1:0];
    assign byte_offset = bus.req_addr[OFFSET_BITS-1:0];
    assign wr_en       = bus.req_valid && (bus.req_type == mem_req_pkg::WRITE);
    assign rd_en       = bus.req_valid && (bus.req_type == mem_req_pkg::READ);

    // Bytes touched by a store, offset assumed aligned to the width
    always_comb begin
        case (bus.req_width)
            mem_req_pkg::BYTE: width_mask = 'h1;
            mem_req_pkg::HALF: width_mask = 'h3;
            mem_req_pkg::WORD: width_mask = 'hf;
            default:           width_mask = '0;
        endcase
    end

    assign byte_en = bus.req_writethrough ? (width_mask << byte_offset) : '1;

    // Merge new lanes into the old row
    always_comb begin
        for (int b = 0; b < BLOCK_BYTES; b++) begin
            write_block[b*8 +: 8] = byte_en[b] ? bus.req_block_data[b*8 +: 8]
                                               : mem_array[row_index][b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_array[row_index] <= write_block;
        end
    end

    // Read samples the row before a same-edge write lands
    always_ff @(posedge clk) begin
        rd_data <= mem_array[row_index];
        rd_tag  <= bus.req_cache_type;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid   <= 1'b0;
            pipe_valid <= '0;
        end else begin
            rd_valid   <= rd_en;
            pipe_valid <= {pipe_valid[`MEM_LATENCY-2:0], rd_valid};
        end
    end

    always_ff @(posedge clk) begin
        pipe_tag[0]  <= rd_tag;
        pipe_data[0] <= rd_data;
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            pipe_tag[i]  <= pipe_tag[i-1];
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    assign bus.resp_valid      = pipe_valid[`MEM_LATENCY-1];
    assign bus.resp_cache_type = pipe_tag[`MEM_LATENCY-1];  // Responses leave in order
    assign bus.resp_block_data = pipe_data[`MEM_LATENCY-1];

endmodule

`default_nettype wire

// File: source/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
    input  wire logic                               clk,
    input  wire logic                               rst,

    input  wire logic                               icache_req_valid,
    input  wire mem_data_pkg::main_mem_block_addr_t icache_req_block_addr,
    output logic                                    icache_req_ready,

    input  wire logic                               dcache_req_valid,
    input  wire mem_req_pkg::req_type_t             dcache_req_type,
    input  wire mem_data_pkg::main_mem_block_addr_t dcache_req_block_addr,
    input  wire mem_data_pkg::block_data_t          dcache_req_block_data,
    input  wire mem_req_pkg::req_width_t            dcache_req_width,
    input  wire mem_data_pkg::addr_t                dcache_req_addr,
    input  wire logic                               dcache_req_writethrough,
    output logic                                    dcache_req_ready,

    output logic                                    icache_resp_valid,
    output mem_data_pkg::block_data_t               icache_resp_block_data,
    output logic                                    dcache_resp_valid,
    output mem_data_pkg::block_data_t               dcache_resp_block_data
);

    mem_bus_if mem_bus ();

    // Arbiter and response router, no state
    mem_ctrl u_mem_ctrl (
        .icache_req_valid        (icache_req_valid),
        .icache_req_block_addr   (icache_req_block_addr),
        .icache_req_ready        (icache_req_ready),
        .dcache_req_valid        (dcache_req_valid),
        .dcache_req_type         (dcache_req_type),
        .dcache_req_block_addr   (dcache_req_block_addr),
        .dcache_req_block_data   (dcache_req_block_data),
        .dcache_req_width        (dcache_req_width),
        .dcache_req_addr         (dcache_req_addr),
        .dcache_req_writethrough (dcache_req_writethrough),
        .dcache_req_ready        (dcache_req_ready),
        .mem                     (mem_bus.ctrl),
        .icache_resp_valid       (icache_resp_valid),
        .icache_resp_block_data  (icache_resp_block_data),
        .dcache_resp_valid       (dcache_resp_valid),
        .dcache_resp_block_data  (dcache_resp_block_data)
    );

    main_mem u_main_mem (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus.mem)
    );

endmodule

`default_nettype wire

// File: tests/mem_subsystem_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_props (
    input wire logic clk,
    input wire logic rst,
    input wire logic icache_req_valid,
    input wire logic icache_req_ready,
    input wire logic dcache_req_valid,
    input wire logic dcache_req_ready,
    input wire logic icache_resp_valid,
    input wire logic dcache_resp_valid,
    input wire logic bus_req_valid
);

    // Only one cache is granted per cycle
    one_grant: assert property (@(posedge clk) disable iff (rst)
        !(icache_req_ready && dcache_req_ready))
        else $error("Both request readies high");

    ready_needs_valid: assert property (@(posedge clk) disable iff (rst)
        (!icache_req_ready || icache_req_valid) && (!dcache_req_ready || dcache_req_valid))
        else $error("Request ready high without its valid");

    // A response goes to exactly one cache
    one_response: assert property (@(posedge clk) disable iff (rst)
        !(icache_resp_valid && dcache_resp_valid))
        else $error("Both response valids high");

    bus_valid_or: assert property (@(posedge clk) disable iff (rst)
        bus_req_valid == (icache_req_valid || dcache_req_valid))
        else $error("Bus request valid differs from OR of cache valids");

endmodule

`default_nettype wire

// File: tests/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_subsystem_tb;

    localparam int BLOCK_BYTES = `BLOCK_BITS / 8;
    localparam int WAIT_LIMIT  = 20; // Cycles one wait may take

    logic clk = 1'b0;
    logic rst = 1'b1;
    int   cycle = 0;

    logic                               icache_req_valid;
    mem_data_pkg::main_mem_block_addr_t icache_req_block_addr;
    logic                               icache_req_ready;
    logic                               dcache_req_valid;
    mem_req_pkg::req_type_t             dcache_req_type;
    mem_data_pkg::main_mem_block_addr_t dcache_req_block_addr;
    mem_data_pkg::block_data_t          dcache_req_block_data;
    mem_req_pkg::req_width_t            dcache_req_width;
    mem_data_pkg::addr_t                dcache_req_addr;
    logic                               dcache_req_writethrough;
    logic                               dcache_req_ready;
    logic                               icache_resp_valid;
    mem_data_pkg::block_data_t          icache_resp_block_data;
    logic                               dcache_resp_valid;
    mem_data_pkg::block_data_t          dcache_resp_block_data;

    // Reference memory and expected reads, per cache
    mem_data_pkg::block_data_t model_mem [`MEM_DEPTH];
    mem_data_pkg::block_data_t icache_exp_data [$];
    int                        icache_exp_cycle [$];
    mem_data_pkg::block_data_t dcache_exp_data [$];
    int                        dcache_exp_cycle [$];

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    mem_subsystem u_mem_subsystem (
        .clk                     (clk),
        .rst                     (rst),
        .icache_req_valid        (icache_req_valid),
        .icache_req_block_addr   (icache_req_block_addr),
        .icache_req_ready        (icache_req_ready),
        .dcache_req_valid        (dcache_req_valid),
        .dcache_req_type         (dcache_req_type),
        .dcache_req_block_addr   (dcache_req_block_addr),
        .dcache_req_block_data   (dcache_req_block_data),
        .dcache_req_width        (dcache_req_width),
        .dcache_req_addr         (dcache_req_addr),
        .dcache_req_writethrough (dcache_req_writethrough),
        .dcache_req_ready        (dcache_req_ready),
        .icache_resp_valid       (icache_resp_valid),
        .icache_resp_block_data  (icache_resp_block_data),
        .dcache_resp_valid       (dcache_resp_valid),
        .dcache_resp_block_data  (dcache_resp_block_data)
    );

    bind mem_ctrl mem_subsystem_props u_props (
        .clk               (mem_subsystem_tb.clk),
        .rst               (mem_subsystem_tb.rst),
        .icache_req_valid  (icache_req_valid),
        .icache_req_ready  (icache_req_ready),
        .dcache_req_valid  (dcache_req_valid),
        .dcache_req_ready  (dcache_req_ready),
        .icache_resp_valid (icache_resp_valid),
        .dcache_resp_valid (dcache_resp_valid),
        .bus_req_valid     (mem.req_valid)
    );

    function automatic int width_bytes(input mem_req_pkg::req_width_t width);
        case (width)
            mem_req_pkg::BYTE: return 1;
            mem_req_pkg::HALF: return 2;
            mem_req_pkg::WORD: return 4;
            default:           return 0;
        endcase
    endfunction

    // Plain write takes the whole block, write-through only the stored lanes
    function automatic mem_data_pkg::block_data_t expected_after_write(
        input mem_data_pkg::block_data_t old_block,
        input mem_data_pkg::block_data_t new_block,
        input logic                      writethrough,
        input mem_req_pkg::req_width_t   width,
        input mem_data_pkg::addr_t       addr
    );
        mem_data_pkg::block_data_t result;
        int                        first;
        int                        nbytes;
        if (!writethrough) return new_block;
        result = old_block;
        first  = int'(addr[3:0]);
        nbytes = width_bytes(width);
        for (int b = 0; b < BLOCK_BYTES; b++) begin
            if (b >= first && b < first + nbytes) result[b*8 +: 8] = new_block[b*8 +: 8];
        end
        return result;
    endfunction

    function automatic mem_data_pkg::block_data_t random_block();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_block(input string name, input mem_data_pkg::block_data_t expected,
                               input mem_data_pkg::block_data_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Quiet bus, no readies and no responses
    task automatic check_idle();
        check_flag("icache_req_ready", 1'b0, icache_req_ready);
        check_flag("dcache_req_ready", 1'b0, dcache_req_ready);
        check_flag("icache_resp_valid", 1'b0, icache_resp_valid);
        check_flag("dcache_resp_valid", 1'b0, dcache_resp_valid);
    endtask

    // Called at a falling edge, holds each request until its edge of acceptance
    task automatic issue(
        input logic i_valid, input mem_data_pkg::main_mem_block_addr_t i_addr,
        input logic d_valid, input mem_req_pkg::req_type_t d_type,
        input mem_data_pkg::main_mem_block_addr_t d_addr, input mem_data_pkg::block_data_t d_data,
        input mem_req_pkg::req_width_t d_width, input mem_data_pkg::addr_t d_byte_addr,
        input logic d_wt
    );
        logic i_acc;
        logic d_acc;
        logic [`MEM_INDEX_BITS-1:0] idx;
        int   waited;
        waited                  = 0;
        icache_req_valid        = i_valid;
        icache_req_block_addr   = i_addr;
        dcache_req_valid        = d_valid;
        dcache_req_type         = d_type;
        dcache_req_block_addr   = d_addr;
        dcache_req_block_data   = d_data;
        dcache_req_width        = d_width;
        dcache_req_addr         = d_byte_addr;
        dcache_req_writethrough = d_wt;
        while (icache_req_valid || dcache_req_valid) begin
            @(posedge clk);
            check_flag("icache_req_ready", icache_req_valid, icache_req_ready);
            check_flag("dcache_req_ready", dcache_req_valid && !icache_req_valid,
                       dcache_req_ready);
            i_acc = icache_req_valid && icache_req_ready;
            d_acc = dcache_req_valid && dcache_req_ready;
            if (i_acc) begin
                icache_exp_data.push_back(model_mem[icache_req_block_addr[`MEM_INDEX_BITS-1:0]]);
                icache_exp_cycle.push_back(cycle + `MEM_LATENCY + 1);
            end
            idx = dcache_req_block_addr[`MEM_INDEX_BITS-1:0];
            if (d_acc && dcache_req_type == mem_req_pkg::READ) begin
                dcache_exp_data.push_back(model_mem[idx]);
                dcache_exp_cycle.push_back(cycle + `MEM_LATENCY + 1);
            end else if (d_acc) begin
                model_mem[idx] = expected_after_write(model_mem[idx], dcache_req_block_data,
                    dcache_req_writethrough, dcache_req_width, dcache_req_addr);
            end
            @(negedge clk);
            if (i_acc) icache_req_valid = 1'b0;
            if (d_acc) dcache_req_valid = 1'b0;
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("A cache request was not accepted within %0d cycles", WAIT_LIMIT);
                abort_run();
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (icache_exp_data.size() != 0 || dcache_exp_data.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Read responses still missing after %0d cycles", WAIT_LIMIT);
                abort_run();
            end
        end
    endtask

    // Responses sampled mid-cycle, each against its own cache's queue
    always @(negedge clk) begin
        if (icache_resp_valid) begin
            if (icache_exp_data.size() == 0 || icache_exp_cycle[0] != cycle) begin
                $display("Instruction cache got a response it did not expect at cycle %0d", cycle);
                abort_run();
            end
            void'(icache_exp_cycle.pop_front());
            check_block("icache_resp_block_data", icache_exp_data.pop_front(),
                        icache_resp_block_data);
        end else begin
            check_block("icache_resp_block_data", '0, icache_resp_block_data);
        end
        if (dcache_resp_valid) begin
            if (dcache_exp_data.size() == 0 || dcache_exp_cycle[0] != cycle) begin
                $display("Data cache got a response it did not expect at cycle %0d", cycle);
                abort_run();
            end
            void'(dcache_exp_cycle.pop_front());
            check_block("dcache_resp_block_data", dcache_exp_data.pop_front(),
                        dcache_resp_block_data);
        end else begin
            check_block("dcache_resp_block_data", '0, dcache_resp_block_data);
        end
    end

    initial begin
        mem_data_pkg::main_mem_block_addr_t a;
        mem_req_pkg::req_width_t            w;
        logic [3:0]                         off;
        logic                               i_v;
        void'($urandom(32'hc369fa22));
        icache_req_valid        = 1'b0;
        icache_req_block_addr   = '0;
        dcache_req_valid        = 1'b0;
        dcache_req_type         = mem_req_pkg::READ;
        dcache_req_block_addr   = '0;
        dcache_req_block_data   = '0;
        dcache_req_width        = mem_req_pkg::WORD;
        dcache_req_addr         = '0;
        dcache_req_writethrough = 1'b0;
        for (int r = 0; r < `MEM_DEPTH; r++) model_mem[r] = '0;

        // Quiet bus through reset and a few idle cycles
        repeat (5) begin
            @(posedge clk);
            check_idle();
        end
        @(negedge clk);
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end

        // Fetch of a never-written block
        issue(1'b1, 28'h0000033, 1'b0, mem_req_pkg::READ, '0, '0, mem_req_pkg::WORD, '0, 1'b0);
        wait_drain();

        a = 28'h0000010;
        issue(1'b0, '0, 1'b1, mem_req_pkg::WRITE, a, random_block(), mem_req_pkg::WORD, '0, 1'b0);
        issue(1'b0, '0, 1'b1, mem_req_pkg::READ, a, '0, mem_req_pkg::WORD, '0, 1'b0);
        wait_drain();

        // Both caches at once, fetch goes first
        issue(1'b1, a, 1'b1, mem_req_pkg::READ, 28'h0000033, '0, mem_req_pkg::WORD, '0, 1'b0);
        wait_drain();

        a = 28'h00000a5;
        issue(1'b0, '0, 1'b1, mem_req_pkg::WRITE, a, random_block(), mem_req_pkg::WORD, '0, 1'b0);
        issue(1'b0, '0, 1'b1, mem_req_pkg::WRITE, a, random_block(), mem_req_pkg::BYTE,
              {a, 4'h5}, 1'b1);
        issue(1'b0, '0, 1'b1, mem_req_pkg::WRITE, a, random_block(), mem_req_pkg::HALF,
              {a, 4'ha}, 1'b1);
        issue(1'b0, '0, 1'b1, mem_req_pkg::WRITE, a, random_block(), mem_req_pkg::WORD,
              {a, 4'hc}, 1'b1);
        issue(1'b0, '0, 1'b1, mem_req_pkg::WRITE, a, random_block(), mem_req_pkg::BYTE,
              {a, 4'h0}, 1'b1);
        issue(1'b0, '0, 1'b1, mem_req_pkg::READ, a, '0, mem_req_pkg::WORD, '0, 1'b0);
        wait_drain();

        // Random traffic on few rows, upper address bits alias
        for (int n = 0; n < 60; n++) begin
            i_v = 1'($urandom_range(1));
            w   = mem_req_pkg::req_width_t'(2'($urandom_range(2)));
            off = 4'($urandom_range(15)) & ~4'(width_bytes(w) - 1);
            a   = {20'($urandom), 8'($urandom_range(7))};
            issue(i_v, {20'($urandom), 8'($urandom_range(7))}, !i_v || 1'($urandom_range(1)),
                  mem_req_pkg::req_type_t'(1'($urandom_range(1))), a, random_block(), w,
                  {a, off}, 1'($urandom_range(1)));
        end
        wait_drain();
        repeat (3) @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/mem_data_pkg.sv
source/mem_req_pkg.sv
source/mem_bus_if.sv
source/mem_ctrl.sv
source/main_mem.sv
source/mem_subsystem.sv
tests/mem_subsystem_props.sv
tests/mem_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run with Verilator, verdict comes from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module mem_subsystem_tb -f all.f -o sim_tb \
    > build.log 2>&1 && ./obj_dir/sim_tb > sim.log 2>&1 || echo "Build or run aborted" >> sim.log
grep -q "TEST FAILED" sim.log && { echo "FAIL"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"
